// ==== Bender.yml ====
package:
  name: if_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/branch_prediction_unit.sv
      - hdl/if_stage.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/if_stage_asserts.sv
      - sim/if_stage_tb.sv

// ==== hdl/branch_prediction_unit.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module branch_prediction_unit
	import fetch_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic [`XLEN-1:0]  pc,                 // fetch pc to look up
	input  logic [`XLEN-1:0]  ex_pc,              // pc of resolved branch in execute
	input  logic              ex_branch,          // update strobe
	input  logic              ex_taken,           // resolved direction
	input  logic [`XLEN-1:0]  ex_target_pc,       // resolved target
	output logic              predict_taken,      // lookup result
	output logic [`XLEN-1:0]  predict_target_pc   // predicted next fetch pc
);

	////////////////////
	// geometry
	////////////////////

	localparam int idx_bits = `BTB_IDX_BITS;
	localparam int tag_bits = `XLEN - `BTB_IDX_BITS - 2;  // bits above the index
	localparam int entries  = 2 ** idx_bits;

	////////////////////
	// storage
	////////////////////

	// control state, cleared by reset
	logic [entries-1:0] valid_bits;      // one per entry, set by a taken update
	bp_state_t          counters [entries];

	// payload, written only on taken updates
	logic [tag_bits-1:0] tags    [entries];
	logic [`XLEN-1:0]    targets [entries];

	////////////////////
	// counter step
	////////////////////

	// one step toward the resolved direction, saturating at both ends
	function automatic bp_state_t bp_step(input bp_state_t state, input logic taken);
		bp_state_t next_state;
		next_state = state;
		case (state)
			strong_not_taken: begin
				next_state = taken ? weak_not_taken : strong_not_taken;
			end
			weak_not_taken: begin
				next_state = taken ? weak_taken : strong_not_taken;
			end
			weak_taken: begin
				next_state = taken ? strong_taken : weak_not_taken;
			end
			strong_taken: begin
				next_state = taken ? strong_taken : weak_taken;
			end
			default: begin
				next_state = weak_not_taken;  // unreachable with a 2-bit enum
			end
		endcase
		return next_state;
	endfunction

	////////////////////
	// lookup
	////////////////////

	logic [idx_bits-1:0] look_idx;
	logic [tag_bits-1:0] look_tag;
	logic                look_hit;
	bp_state_t           look_state;

	assign look_idx   = pc[2 +: idx_bits];        // word index, skip byte offset
	assign look_tag   = pc[`XLEN-1 -: tag_bits];  // everything above the index
	assign look_state = counters[look_idx];

	// invalid entries never hit, their tag is don't care
	assign look_hit = valid_bits[look_idx] && (tags[look_idx] == look_tag);

	always_comb begin
		predict_taken = 1'b0;
		if (look_hit) begin
			// counter msb is the direction
			predict_taken = look_state inside {weak_taken, strong_taken};
		end
	end

	// predicted next pc
	// stored target on a taken prediction, fall-through otherwise
	assign predict_target_pc = predict_taken ? targets[look_idx] : pc + `XLEN'(4);

	////////////////////
	// update decode
	////////////////////

	logic [idx_bits-1:0] upd_idx;
	logic [tag_bits-1:0] upd_tag;
	logic                upd_hit;
	bp_state_t           upd_base;    // counter value the step starts from
	bp_state_t           upd_state;   // counter value written back

	assign upd_idx = ex_pc[2 +: idx_bits];
	assign upd_tag = ex_pc[`XLEN-1 -: tag_bits];
	assign upd_hit = valid_bits[upd_idx] && (tags[upd_idx] == upd_tag);

	always_comb begin
		// a different owner (or an empty slot) starts over from weak not taken
		if (upd_hit) begin
			upd_base = counters[upd_idx];
		end else begin
			upd_base = weak_not_taken;
		end
		upd_state = bp_step(upd_base, ex_taken);
	end

	////////////////////
	// control update
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;                   // empty table, nothing predicts taken
			for (int i = 0; i < entries; i++) begin
				counters[i] <= weak_not_taken;
			end
		end else if (ex_branch) begin
			counters[upd_idx] <= upd_state;      // every resolved branch trains the counter
			if (ex_taken) begin
				valid_bits[upd_idx] <= 1'b1;     // entry now owns a target
			end
		end
	end

	////////////////////
	// payload update
	////////////////////

	// tag and target only move on taken branches
	// a not-taken update keeps the old target in place
	always_ff @(posedge clock) begin
		if (ex_branch && ex_taken) begin
			tags[upd_idx]    <= upd_tag;
			targets[upd_idx] <= ex_target_pc;
		end
	end

endmodule

// ==== hdl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////
// datapath widths
////////////////////

// pc and address width, one machine word
`define XLEN 32

////////////////////
// branch predictor
////////////////////

// log2 of the btb / counter table depth
// 4 gives 16 direct-mapped entries
// index comes from pc[2 +: BTB_IDX_BITS], pc[1:0] are always zero
`define BTB_IDX_BITS 4

////////////////////
// reset values
////////////////////

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	////////////////////
	// memory block
	////////////////////

	// one 64-bit line from the instruction memory
	// seen either as the raw doubleword or as two instructions
	typedef union packed {
		logic [63:0] dword;        // whole block as returned by memory
		logic [1:0][31:0] insts;   // insts[0] is bits 31:0, the lower address
	} mem_block_t;

	////////////////////
	// branch counters
	////////////////////

	// 2-bit saturating counter per predictor entry
	// msb set means predict taken
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,  // saturated low
		weak_not_taken   = 2'b01,  // reset / restart state
		weak_taken       = 2'b10,
		strong_taken     = 2'b11   // saturated high
	} bp_state_t;

endpackage

// ==== hdl/if_stage.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module if_stage
	import fetch_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              if_enable,             // allow pc to advance
	input  logic [`XLEN-1:0]  ex_pc,                 // pc of branch in execute
	input  logic              ex_branch,             // branch resolved this cycle
	input  logic              ex_take_branch,        // its direction
	input  logic              branch_misprediction,  // redirect strobe
	input  logic [`XLEN-1:0]  ex_target_pc,          // correct target on redirect
	input  mem_block_t        imem_data,             // block at imem_addr
	output logic [`XLEN-1:0]  imem_addr,             // doubleword aligned fetch address
	output logic [31:0]       inst,                  // selected instruction
	output logic [`XLEN-1:0]  pc,                    // pc of inst
	output logic [`XLEN-1:0]  npc,                   // pc + 4
	output logic              predict_taken,         // from predictor
	output logic [`XLEN-1:0]  predict_target_pc      // from predictor
);

	////////////////////
	// pc datapath
	////////////////////

	logic [`XLEN-1:0] pc_reg;       // address being fetched this cycle
	logic [`XLEN-1:0] pc_plus_4;    // sequential successor
	logic [`XLEN-1:0] next_pc;      // mux output, loaded on enable
	logic             pc_load;      // register enable

	assign pc_plus_4 = pc_reg + `XLEN'(4);

	// a redirect must land even during a stall
	assign pc_load = if_enable | branch_misprediction;

	// priority mux
	always_comb begin
		if (branch_misprediction) begin
			next_pc = ex_target_pc;          // execute knows best
		end else if (predict_taken) begin
			next_pc = predict_target_pc;     // follow the btb
		end else begin
			next_pc = pc_plus_4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= `RESET_PC;
		end else if (pc_load) begin
			pc_reg <= next_pc;
		end                                  // else hold, stall
	end

	////////////////////
	// memory side
	////////////////////

	// memory returns 64 bits, so drop the low three address bits
	assign imem_addr = {pc_reg[`XLEN-1:3], 3'b000};

	// pc[2] picks the upper or lower word of the block
	assign inst = imem_data.insts[pc_reg[2]];

	////////////////////
	// to decode
	////////////////////

	assign pc  = pc_reg;
	assign npc = pc_plus_4;

	// predictor, lookup on the current pc, trained from execute
	branch_prediction_unit bpu_0 (
		.clock             (clock),
		.reset             (reset),
		.pc                (pc_reg),
		.ex_pc             (ex_pc),
		.ex_branch         (ex_branch),
		.ex_taken          (ex_take_branch),
		.ex_target_pc      (ex_target_pc),
		.predict_taken     (predict_taken),
		.predict_target_pc (predict_target_pc)
	);

endmodule

// ==== sim/if_stage_asserts.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module if_stage_asserts
	import fetch_pkg::*;
(
	input logic              clock,
	input logic              reset,
	input logic              if_enable,
	input logic              branch_misprediction,
	input logic [`XLEN-1:0]  ex_target_pc,
	input logic              predict_taken,
	input logic [`XLEN-1:0]  predict_target_pc,
	input logic [`XLEN-1:0]  pc,
	input logic [`XLEN-1:0]  npc,
	input logic [`XLEN-1:0]  imem_addr,
	input logic [31:0]       inst,
	input mem_block_t        imem_data
);

	int fail_count = 0;  // fetch rule violations seen so far

	////////////////////
	// combinational outputs
	////////////////////

	npc_is_pc_plus_4: assert property (@(posedge clock) disable iff (reset)
		npc == pc + `XLEN'(4))
	else begin
		$error("npc is not the pc plus four");
		fail_count++;
	end

	imem_addr_aligned: assert property (@(posedge clock) disable iff (reset)
		imem_addr == {pc[`XLEN-1:3], 3'b000})  // doubleword address of pc
	else begin
		$error("imem_addr is not the pc with its low three bits cleared");
		fail_count++;
	end

	// low word at pc[2] == 0, high word otherwise
	inst_half_select: assert property (@(posedge clock) disable iff (reset)
		inst == (pc[2] ? imem_data.dword[63:32] : imem_data.dword[31:0]))
	else begin
		$error("inst is not the memory half picked by pc bit 2");
		fail_count++;
	end

	////////////////////
	// pc sequencing
	////////////////////

	reset_loads_pc: assert property (@(posedge clock)
		reset |=> pc == `RESET_PC)
	else begin
		$error("pc did not return to the reset address");
		fail_count++;
	end

	stall_holds_pc: assert property (@(posedge clock) disable iff (reset)
		!if_enable && !branch_misprediction |=> pc == $past(pc))
	else begin
		$error("pc moved during a stall");
		fail_count++;
	end

	// redirect wins over stall and over the prediction
	redirect_loads_target: assert property (@(posedge clock) disable iff (reset)
		branch_misprediction |=> pc == $past(ex_target_pc))
	else begin
		$error("misprediction did not load the execute target");
		fail_count++;
	end

	predicted_fetch: assert property (@(posedge clock) disable iff (reset)
		if_enable && !branch_misprediction && predict_taken |=> pc == $past(predict_target_pc))
	else begin
		$error("taken prediction was not followed");
		fail_count++;
	end

	sequential_fetch: assert property (@(posedge clock) disable iff (reset)
		if_enable && !branch_misprediction && !predict_taken |=> pc == $past(pc) + `XLEN'(4))
	else begin
		$error("sequential fetch did not advance by four");
		fail_count++;
	end

endmodule

// ==== sim/if_stage_tb.sv ====
`timescale 1ns/10ps

`include "fetch_params.svh"

module if_stage_tb
	import fetch_pkg::*;
();

	localparam int reset_cycles   = 10;
	localparam int seq_cycles     = 40;
	localparam int random_cycles  = 300;
	localparam int fixed_cycles   = 40;   // stall, training, aliasing and priority together
	localparam int timeout_cycles = reset_cycles + seq_cycles + random_cycles + fixed_cycles + 50;
	localparam int entries        = 2 ** `BTB_IDX_BITS;

	logic              clock;
	logic              reset;
	logic              if_enable;
	logic [`XLEN-1:0]  ex_pc;
	logic              ex_branch;
	logic              ex_take_branch;
	logic              branch_misprediction;
	logic [`XLEN-1:0]  ex_target_pc;
	mem_block_t        imem_data;
	logic [`XLEN-1:0]  imem_addr;
	logic [31:0]       inst;
	logic [`XLEN-1:0]  pc;
	logic [`XLEN-1:0]  npc;
	logic              predict_taken;
	logic [`XLEN-1:0]  predict_target_pc;

	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int test_err_start;
	int test_asrt_start;
	logic [15:0] lfsr_state = 16'd48930;
	logic [`XLEN-1:0] exp_pc;               // where the fetch should be this cycle

	// reference predictor state
	logic             model_valid [entries];
	logic [`XLEN-1:0] model_tag   [entries];  // address shifted past index and offset
	logic [`XLEN-1:0] model_tgt   [entries];
	bp_state_t        model_cnt   [entries];

	if_stage if_stage_inst (.*);

	bind if_stage if_stage_asserts asserts_0 (
		.clock(clock), .reset(reset), .if_enable(if_enable),
		.branch_misprediction(branch_misprediction), .ex_target_pc(ex_target_pc),
		.predict_taken(predict_taken), .predict_target_pc(predict_target_pc),
		.pc(pc), .npc(npc), .imem_addr(imem_addr), .inst(inst), .imem_data(imem_data)
	);

	////////////////////
	// clock and memory
	////////////////////

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;  // 100 ns period
	end

	// instruction word stored at a byte address
	function automatic logic [31:0] inst_at(input logic [`XLEN-1:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B9) ^ 32'h1357_2468;
	endfunction

	function automatic mem_block_t mem_block_at(input logic [`XLEN-1:0] addr);
		mem_block_t blk;
		blk.insts[0] = inst_at({addr[`XLEN-1:3], 3'b000});  // lower address
		blk.insts[1] = inst_at({addr[`XLEN-1:3], 3'b100});
		return blk;
	endfunction

	assign imem_data = mem_block_at(imem_addr);  // zero-latency memory

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("timeout: the run went past %0d cycles without finishing", timeout_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// lfsr
	////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	////////////////////
	// reference model
	////////////////////

	function automatic bp_state_t saturate_step(input bp_state_t s, input logic taken);
		logic [1:0] v;
		v = s;
		if (taken && v != 2'b11) v = v + 2'd1;          // toward strong taken
		else if (!taken && v != 2'b00) v = v - 2'd1;    // toward strong not taken
		return bp_state_t'(v);
	endfunction

	function automatic logic model_taken(input logic [`XLEN-1:0] addr);
		int idx;
		idx = addr[2 +: `BTB_IDX_BITS];
		return model_valid[idx] && model_tag[idx] == (addr >> (`BTB_IDX_BITS + 2))
			&& (model_cnt[idx] == weak_taken || model_cnt[idx] == strong_taken);
	endfunction

	function automatic logic [`XLEN-1:0] model_target(input logic [`XLEN-1:0] addr);
		return model_taken(addr) ? model_tgt[addr[2 +: `BTB_IDX_BITS]] : addr + 4;
	endfunction

	task automatic model_update(input logic [`XLEN-1:0] addr, input logic taken,
		input logic [`XLEN-1:0] target);
		int idx;
		logic [`XLEN-1:0] tag;
		bp_state_t start;
		idx = addr[2 +: `BTB_IDX_BITS];
		tag = addr >> (`BTB_IDX_BITS + 2);
		if (model_valid[idx] && model_tag[idx] == tag) start = model_cnt[idx];
		else start = weak_not_taken;   // new owner starts over
		model_cnt[idx] = saturate_step(start, taken);
		if (taken) begin
			model_valid[idx] = 1'b1;
			model_tag[idx] = tag;
			model_tgt[idx] = target;
		end
	endtask

	////////////////////
	// checks and driving
	////////////////////

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		assert (got === expected) else begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_outputs();
		compare_value("pc", pc, exp_pc);
		compare_value("predict_taken", 32'(predict_taken), 32'(model_taken(exp_pc)));
		compare_value("predict_target_pc", predict_target_pc, model_target(exp_pc));
		compare_value("inst", inst, inst_at(exp_pc));
	endtask

	// called at a falling edge, returns at the next one
	task automatic run_cycle(input logic en, input logic br, input logic taken,
		input logic [`XLEN-1:0] bpc, input logic [`XLEN-1:0] tgt, input logic mis);
		logic [`XLEN-1:0] next_pc;
		check_outputs();
		if_enable = en;
		ex_branch = br;
		ex_take_branch = taken;
		ex_pc = bpc;
		ex_target_pc = tgt;
		branch_misprediction = mis;
		if (mis) next_pc = tgt;
		else if (en) next_pc = model_target(exp_pc);  // prediction before this update
		else next_pc = exp_pc;
		if (br) model_update(bpc, taken, tgt);
		@(negedge clock);
		exp_pc = next_pc;
	endtask

	task automatic start_test();
		test_err_start = error_count;
		test_asrt_start = if_stage_inst.asserts_0.fail_count;
	endtask

	task automatic finish_test(input string name);
		int new_errors;
		new_errors = (error_count - test_err_start)
			+ (if_stage_inst.asserts_0.fail_count - test_asrt_start);
		tests_run++;
		if (new_errors != 0) tests_failed++;
		$display("test %-10s %s, %0d errors", name, (new_errors == 0) ? "ok" : "FAILED", new_errors);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset();
		start_test();
		for (int i = 0; i < entries; i++) begin
			model_valid[i] = 1'b0;
			model_cnt[i] = weak_not_taken;
		end
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		exp_pc = `RESET_PC;
		compare_value("pc", pc, `RESET_PC);
		compare_value("imem_addr", imem_addr, 32'h0);
		compare_value("predict_taken", 32'(predict_taken), 32'h0);
		finish_test("reset");
	endtask

	task automatic test_sequential();
		start_test();
		repeat (seq_cycles) run_cycle(1, 0, 0, '0, '0, 0);
		finish_test("sequential");
	endtask

	task automatic test_stall();
		start_test();
		repeat (4) run_cycle(0, 0, 0, '0, '0, 0);
		run_cycle(0, 0, 0, '0, 32'h0000_0404, 1);  // redirect while stalled
		repeat (3) run_cycle(0, 0, 0, '0, '0, 0);
		repeat (3) run_cycle(1, 0, 0, '0, '0, 0);
		finish_test("stall");
	endtask

	task automatic test_training();
		start_test();
		run_cycle(0, 1, 1, 32'h0000_0100, 32'h0000_0840, 0);  // one taken update
		run_cycle(0, 0, 0, '0, 32'h0000_0100, 1);
		compare_value("predict_taken", 32'(predict_taken), 32'h1);
		run_cycle(1, 0, 0, '0, '0, 0);                        // jumps to 0x840
		run_cycle(0, 1, 0, 32'h0000_0100, '0, 0);
		run_cycle(0, 1, 0, 32'h0000_0100, '0, 0);
		run_cycle(0, 0, 0, '0, 32'h0000_0100, 1);
		compare_value("predict_taken", 32'(predict_taken), 32'h0);
		run_cycle(1, 0, 0, '0, '0, 0);
		run_cycle(1, 0, 0, '0, '0, 0);
		finish_test("training");
	endtask

	task automatic test_random();
		logic [31:0] r;
		logic en;
		logic br;
		logic tk;
		logic mis;
		logic [`XLEN-1:0] bpc;
		logic [`XLEN-1:0] tgt;
		start_test();
		for (int i = 0; i < random_cycles; i++) begin
			en = (random_bits(2) != 0);   // enabled three cycles in four
			br = (random_bits(1) != 0);
			tk = (random_bits(1) != 0);
			mis = (random_bits(3) == 0);
			r = random_bits(6);
			bpc = {24'h0, r[5:0], 2'b00};  // two tag bits over a full index
			r = random_bits(6);
			tgt = {24'h0, r[5:0], 2'b00};  // keep the fetch near trained pcs
			run_cycle(en, br, tk, bpc, tgt, mis);
		end
		finish_test("random");
	endtask

	// 0x148 and 0x1148 share index 2
	task automatic test_aliasing();
		start_test();
		run_cycle(0, 1, 1, 32'h0000_0148, 32'h0000_0900, 0);
		run_cycle(0, 1, 1, 32'h0000_0148, 32'h0000_0900, 0);
		run_cycle(0, 0, 0, '0, 32'h0000_1148, 1);
		compare_value("predict_taken", 32'(predict_taken), 32'h0);  // tag mismatch
		run_cycle(0, 1, 1, 32'h0000_1148, 32'h0000_0A00, 0);        // restart, then step
		run_cycle(0, 0, 0, '0, 32'h0000_0148, 1);
		run_cycle(1, 0, 0, '0, '0, 0);
		run_cycle(0, 1, 0, 32'h0000_1148, '0, 0);
		run_cycle(0, 0, 0, '0, 32'h0000_1148, 1);
		compare_value("predict_taken", 32'(predict_taken), 32'h0);  // weak taken minus one
		run_cycle(1, 0, 0, '0, '0, 0);
		finish_test("aliasing");
	endtask

	task automatic test_priority();
		start_test();
		run_cycle(0, 1, 1, 32'h0000_1148, 32'h0000_0A00, 0);
		run_cycle(0, 0, 0, '0, 32'h0000_1148, 1);
		compare_value("predict_taken", 32'(predict_taken), 32'h1);
		run_cycle(1, 0, 0, '0, 32'h0000_0300, 1);  // redirect beats the prediction
		run_cycle(1, 0, 0, '0, '0, 0);
		check_outputs();
		finish_test("priority");
	endtask

	initial begin
		reset = 1'b1;
		if_enable = 1'b0;
		ex_pc = '0;
		ex_branch = 1'b0;
		ex_take_branch = 1'b0;
		branch_misprediction = 1'b0;
		ex_target_pc = '0;
		exp_pc = `RESET_PC;
		test_reset();
		test_sequential();
		test_stall();
		test_training();
		test_random();
		test_aliasing();
		test_priority();
		@(posedge clock);  // let the last concurrent checks fire
		#1;
		$display("tests %0d, failed %0d, checks %0d, check errors %0d, assertion errors %0d",
			tests_run, tests_failed, check_count, error_count,
			if_stage_inst.asserts_0.fail_count);
		if (error_count == 0 && if_stage_inst.asserts_0.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/branch_prediction_unit.sv
hdl/if_stage.sv
sim/if_stage_asserts.sv
sim/if_stage_tb.sv
